// ==== tb.f ====
+incdir+.
pdp_bus_pkg.sv
mmu_pkg.sv
mmu_regs.sv
mmu_page.sv
mmu_translate.sv
ram_sync.sv
pdp_mem_top.sv
tb_pdp_mem.sv

// ==== Makefile ====
# Verilator simulation of the PDP memory path testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_pdp_mem -o tb_pdp_mem
	./obj_dir/tb_pdp_mem | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== tb_pdp_mem.sv ====
/*
 * PDP memory path testbench
 * xorshift traffic on the CPU and page register ports, checked against a model
 */

`include "pdp_config.svh"

module tb_pdp_mem;

   import pdp_bus_pkg::*;

   localparam int PERIOD = 8;
   localparam int RAM_WORDS = 2 ** `PDP_RAM_ADDR_BITS;
   localparam int RAND_OPS = 600;
   localparam int TEST_CYCLES = RAM_WORDS + 4 * RAND_OPS + 200;
   localparam int WATCHDOG_CYCLES = 5 + TEST_CYCLES + 100;
   localparam logic [7:0] PDR0 = 8'(`PDP_PXR_PDR_BASE);
   localparam logic [7:0] PAR0 = 8'(`PDP_PXR_PAR_BASE);
   localparam logic [7:0] SR0 = 8'(`PDP_PXR_SR0);

   logic        sysclk;
   logic        rst;
   bus_req_t    cpu_req;
   word_t       bus_data_out;
   logic        bus_ack;
   logic        bus_error;
   logic        pxr_wr;
   logic        pxr_rd;
   logic [1:0]  pxr_be;
   logic [7:0]  pxr_addr;
   word_t       pxr_data_in;
   word_t       pxr_data_out;
   logic        mmu_enable;

   // reference model state as it stands after the last driven edge
   logic [11:0] m_par [8];
   logic [6:0]  m_plf [8];
   logic        m_ed [8];
   logic [2:0]  m_acf [8];
   logic        m_w [8];
   word_t       m_sr0;
   logic        m_frozen;
   word_t       m_ram [RAM_WORDS];

   logic        exp_ack;
   logic        exp_err;
   logic        exp_rd;
   logic        exp_pxr;
   word_t       exp_data;
   word_t       exp_pxr_data;
   int          err_count;
   logic [31:0] rng_state;

   pdp_mem_top i_pdp_mem_top (
      .sysclk(sysclk), .rst(rst), .cpu_req(cpu_req),
      .bus_data_out(bus_data_out), .bus_ack(bus_ack), .bus_error(bus_error),
      .pxr_wr(pxr_wr), .pxr_rd(pxr_rd), .pxr_be(pxr_be), .pxr_addr(pxr_addr),
      .pxr_data_in(pxr_data_in), .pxr_data_out(pxr_data_out),
      .mmu_enable(mmu_enable));

   initial
   begin
      sysclk = 1'b0;
      forever #(PERIOD / 2) sysclk = ~sysclk;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * PERIOD);
      $display("timeout, the test sequence did not finish in time");
      $display("Testbench failed");
      $finish;
   end

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   task automatic report_mismatch(string name, logic [15:0] expected, logic [15:0] actual);
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
      err_count++;
   endtask

   // ----------------------------------------------------------------------
   // check the last cycle's response and return the inputs to idle
   // ----------------------------------------------------------------------

   task automatic next_cycle();
      @(posedge sysclk);
      #1;
      if (bus_ack !== exp_ack)
         report_mismatch("bus_ack", 16'(exp_ack), 16'(bus_ack));
      if (bus_error !== exp_err)
         report_mismatch("bus_error", 16'(exp_err), 16'(bus_error));
      if (mmu_enable !== m_sr0[0])
         report_mismatch("mmu_enable", 16'(m_sr0[0]), 16'(mmu_enable));
      if (exp_rd && bus_data_out !== exp_data)
         report_mismatch("bus_data_out", exp_data, bus_data_out);
      // readback holds from the cycle after a read until the next one
      if (exp_pxr && pxr_data_out !== exp_pxr_data)
         report_mismatch("pxr_data_out", exp_pxr_data, pxr_data_out);
      cpu_req = '0;
      pxr_wr = 1'b0;
      pxr_rd = 1'b0;
      pxr_be = 2'b00;
      pxr_addr = '0;
      pxr_data_in = '0;
      exp_ack = 1'b0;
      exp_err = 1'b0;
      exp_rd = 1'b0;
   endtask

   task automatic cpu_op(vaddr_t va, word_t data, logic wr, logic byte_op);
      logic [2:0]  p;
      logic [6:0]  blk;
      logic [2:0]  cause;
      logic [17:0] pa;
      logic [13:0] idx;
      next_cycle();
      cpu_req.va = va;
      cpu_req.data = data;
      cpu_req.rd = !wr;
      cpu_req.wr = wr;
      cpu_req.byte_op = byte_op;
      p = va[15:13];
      blk = va[12:6];
      // non-resident, length, read-only
      cause[2] = (m_acf[p] != 3'd2) && (m_acf[p] != 3'd6);
      cause[1] = m_ed[p] ? (blk < m_plf[p]) : (blk > m_plf[p]);
      cause[0] = wr && (m_acf[p] == 3'd2);
      if (m_sr0[0])
         pa = 18'(m_par[p]) * 18'd64 + 18'(va[12:0]);
      else if (p == 3'd7)
         pa = 18'(va) + 18'h30000;
      else
         pa = 18'(va);
      idx = pa[`PDP_RAM_ADDR_BITS:1];
      if (m_sr0[0] && cause != 3'b000)
      begin
         exp_err = 1'b1;
         if (!m_frozen)
         begin
            m_sr0[15:13] = cause;
            m_sr0[3:1] = p;
            m_frozen = 1'b1;
         end
      end
      else
      begin
         exp_ack = 1'b1;
         exp_rd = !wr;
         exp_data = m_ram[idx];
         if (wr && byte_op && pa[0])
            m_ram[idx][15:8] = data[7:0];
         else if (wr && byte_op)
            m_ram[idx][7:0] = data[7:0];
         else if (wr)
            m_ram[idx] = data;
         if (wr && m_sr0[0])
            m_w[p] = 1'b1;
      end
   endtask

   task automatic random_cpu_op();
      logic [31:0] r;
      vaddr_t      va;
      r = xorshift32();
      va = vaddr_t'(r >> 16);
      // word cycles stay on even addresses
      if (!r[2])
         va[0] = 1'b0;
      cpu_op(va, 16'(xorshift32()), r[0], r[2]);
   endtask

   task automatic reg_write(logic [7:0] addr, logic [1:0] be, word_t data);
      logic [2:0] p;
      next_cycle();
      pxr_wr = 1'b1;
      pxr_addr = addr;
      pxr_be = be;
      pxr_data_in = data;
      p = addr[2:0];
      if (addr < PAR0)
      begin
         if (be[0])
         begin
            m_ed[p] = data[3];
            m_acf[p] = data[2:0];
         end
         if (be[1])
            m_plf[p] = data[14:8];
         m_w[p] = 1'b0;
      end
      else if (addr < SR0)
      begin
         if (be[0])
            m_par[p][7:0] = data[7:0];
         if (be[1])
            m_par[p][11:8] = data[11:8];
      end
      else
      begin
         if (be[0])
            m_sr0[7:0] = data[7:0];
         if (be[1])
            m_sr0[15:8] = data[15:8];
         m_frozen = 1'b0;
      end
   endtask

   task automatic reg_read(logic [7:0] addr);
      logic [2:0] p;
      next_cycle();
      pxr_rd = 1'b1;
      pxr_addr = addr;
      p = addr[2:0];
      exp_pxr = 1'b1;
      if (addr < PAR0)
         exp_pxr_data = (16'(m_plf[p]) << 8) | (16'(m_w[p]) << 6) | (16'(m_ed[p]) << 3)
                        | 16'(m_acf[p]);
      else if (addr < SR0)
         exp_pxr_data = 16'(m_par[p]);
      else
         exp_pxr_data = m_sr0;
   endtask

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------

   initial
   begin
      int          i;
      logic [31:0] r;
      logic [11:0] base;
      rng_state = 32'h7a3e;
      err_count = 0;
      rst = 1'b1;
      cpu_req = '0;
      pxr_wr = 1'b0;
      pxr_rd = 1'b0;
      pxr_be = 2'b00;
      pxr_addr = '0;
      pxr_data_in = '0;
      exp_ack = 1'b0;
      exp_err = 1'b0;
      exp_rd = 1'b0;
      exp_pxr = 1'b0;
      for (i = 0; i < 8; i++)
      begin
         m_par[i] = '0;
         m_plf[i] = '0;
         m_ed[i] = 1'b0;
         m_acf[i] = '0;
         m_w[i] = 1'b0;
      end
      m_sr0 = '0;
      m_frozen = 1'b0;
      repeat (5) @(posedge sysclk);
      #1;
      rst = 1'b0;

      // with the MMU off fill every word back to back and run random traffic
      for (i = 0; i < RAM_WORDS; i++)
         cpu_op(vaddr_t'(i << 1), 16'((i * 32'h9e37) ^ (i >> 5)), 1'b1, 1'b0);
      repeat (RAND_OPS) random_cpu_op();

      // page registers with random byte enables
      repeat (RAND_OPS / 4)
      begin
         r = xorshift32();
         reg_write(8'(r[3:0]), r[5:4], 16'(r >> 16));
         reg_read(8'(r[3:0]));
      end

      // mapped pages stay inside the RAM and page 5 shares page 1's base
      for (i = 0; i < 8; i++)
      begin
         r = xorshift32();
         base = 12'(r % 385);
         if (i == 5)
            base = m_par[1];
         reg_write(PAR0 + 8'(i), 2'b11, 16'(base));
         reg_write(PDR0 + 8'(i), 2'b11, 16'h7f06);
      end
      reg_write(SR0, 2'b11, 16'h0001);
      repeat (RAND_OPS) random_cpu_op();
      cpu_op(16'h2468, 16'hbeef, 1'b1, 1'b0);
      cpu_op(16'ha468, 16'h0000, 1'b0, 1'b0);

      // written bits before and after a descriptor write clears one
      for (i = 0; i < 8; i++)
         reg_read(PDR0 + 8'(i));
      reg_write(PDR0, 2'b01, 16'h0006);
      reg_read(PDR0);
      cpu_op(16'h0010, 16'h1234, 1'b1, 1'b0);
      reg_read(PDR0);

      // aborts for length up, length down, not resident and read only
      reg_write(PDR0 + 8'd2, 2'b11, 16'h0a06);
      reg_write(PDR0 + 8'd3, 2'b11, 16'h320e);
      reg_write(PDR0 + 8'd4, 2'b11, 16'h7f00);
      reg_write(PDR0 + 8'd6, 2'b11, 16'h7f02);
      cpu_op(16'h4500, 16'h0000, 1'b0, 1'b0);
      reg_read(SR0);
      cpu_op(16'h6280, 16'h5555, 1'b1, 1'b0);
      cpu_op(16'h8040, 16'h0000, 1'b0, 1'b0);
      cpu_op(16'hc100, 16'haaaa, 1'b1, 1'b0);
      cpu_op(16'hc100, 16'h0000, 1'b0, 1'b0);
      cpu_op(16'h4140, 16'h0000, 1'b0, 1'b0);
      cpu_op(16'h6f00, 16'h0000, 1'b0, 1'b0);
      reg_read(SR0);
      reg_write(SR0, 2'b11, 16'h0001);
      cpu_op(16'hc100, 16'h3c3c, 1'b1, 1'b1);
      reg_read(SR0);

      // mixed traffic with random descriptors and SR0 rewrites
      repeat (RAND_OPS)
      begin
         r = xorshift32();
         if (r[3:0] == 4'd0)
            reg_write(PDR0 + 8'(r[6:4]), r[9:8], 16'(r >> 16));
         else if (r[3:0] == 4'd1)
            reg_read(8'(r[8:4] % 17));
         else if (r[3:0] == 4'd2)
            reg_write(SR0, 2'b11, 16'h0001);
         else
            random_cpu_op();
      end

      next_cycle();
      $display("checks complete with %0d errors", err_count);
      if (err_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== pdp_mem_top.sv ====
/*
 * PDP memory path top level
 * register decoder, page units, translator and RAM
 */

`include "pdp_config.svh"

module pdp_mem_top
(
   input  logic                     sysclk,
   input  logic                     rst,
   input  pdp_bus_pkg::bus_req_t    cpu_req,
   output pdp_bus_pkg::word_t       bus_data_out,
   output logic                     bus_ack,
   output logic                     bus_error,
   input  logic                     pxr_wr,
   input  logic                     pxr_rd,
   input  logic [1:0]               pxr_be,
   input  logic [7:0]               pxr_addr,
   input  pdp_bus_pkg::word_t       pxr_data_in,
   output pdp_bus_pkg::word_t       pxr_data_out,
   output logic                     mmu_enable
);

   import pdp_bus_pkg::*;
   import mmu_pkg::*;

   logic [`PDP_PAGES-1:0] pdr_wr;
   logic [`PDP_PAGES-1:0] par_wr;
   logic [`PDP_PAGES-1:0] set_w;
   pxr_wr_t               wr_data;
   word_t                 sr0;
   logic                  abort;
   logic [2:0]            abort_cause;
   page_idx_t             abort_page;
   page_cfg_t             cfgs [`PDP_PAGES];
   page_res_t             results [`PDP_PAGES];
   ram_req_t              ram_req;

   mmu_regs i_regs (
      .sysclk(sysclk), .rst(rst),
      .pxr_wr(pxr_wr), .pxr_rd(pxr_rd), .pxr_be(pxr_be),
      .pxr_addr(pxr_addr), .pxr_data_in(pxr_data_in),
      .abort(abort), .abort_cause(abort_cause), .abort_page(abort_page),
      .pdr_wr(pdr_wr), .par_wr(par_wr), .wr_data(wr_data),
      .sr0(sr0), .mmu_enable(mmu_enable));

   for (genvar i = 0; i < `PDP_PAGES; i++)
   begin : g_page
      mmu_page i_page (
         .sysclk(sysclk), .rst(rst),
         .pdr_wr(pdr_wr[i]), .par_wr(par_wr[i]), .wr_data(wr_data),
         .set_w(set_w[i]), .va(cpu_req.va), .wr(cpu_req.wr),
         .cfg(cfgs[i]), .res(results[i]));
   end

   mmu_translate i_translate (
      .sysclk(sysclk), .rst(rst),
      .req(cpu_req), .mmu_enable(mmu_enable),
      .cfgs(cfgs), .results(results), .sr0(sr0),
      .pxr_rd(pxr_rd), .pxr_addr(pxr_addr),
      .ram_req(ram_req), .set_w(set_w),
      .abort(abort), .abort_cause(abort_cause), .abort_page(abort_page),
      .bus_error(bus_error), .pxr_data_out(pxr_data_out));

   ram_sync #(.ADDR_BITS(`PDP_RAM_ADDR_BITS)) i_ram (
      .sysclk(sysclk), .rst(rst),
      .req(ram_req), .data_out(bus_data_out), .ack(bus_ack));

endmodule

// ==== ram_sync.sv ====
/*
 * Synchronous word RAM
 * byte-lane writes, read data and acknowledge one cycle after the strobe
 */

`include "pdp_config.svh"

module ram_sync
#(
   parameter int ADDR_BITS = `PDP_RAM_ADDR_BITS
)
(
   input  logic                     sysclk,
   input  logic                     rst,
   input  pdp_bus_pkg::ram_req_t    req,
   output pdp_bus_pkg::word_t       data_out,
   output logic                     ack
);

   import pdp_bus_pkg::*;

   word_t                mem [2**ADDR_BITS];
   logic [ADDR_BITS-1:0] idx;
   logic                 we_lo;
   logic                 we_hi;
   logic [7:0]           hi_data;

   // word index, bit 0 selects the byte lane
   assign idx = req.pa[ADDR_BITS:1];

   assign we_lo = req.wr && (!req.byte_op || !req.pa[0]);
   assign we_hi = req.wr && (!req.byte_op || req.pa[0]);

   // a byte write carries its byte in the low half
   assign hi_data = req.byte_op ? req.data[7:0] : req.data[15:8];

   always_ff @(posedge sysclk)
   begin
      if (we_lo)
         mem[idx][7:0] <= req.data[7:0];
      if (we_hi)
         mem[idx][15:8] <= hi_data;
      if (req.rd)
         data_out <= mem[idx];
   end

   always_ff @(posedge sysclk)
   begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= req.rd || req.wr;
   end

endmodule

// ==== mmu_translate.sv ====
/*
 * MMU translator
 * page select, RAM cycle gating, abort report and register readback
 */

`include "pdp_config.svh"

module mmu_translate
(
   input  logic                     sysclk,
   input  logic                     rst,
   input  pdp_bus_pkg::bus_req_t    req,
   input  logic                     mmu_enable,
   input  mmu_pkg::page_cfg_t       cfgs [`PDP_PAGES],
   input  mmu_pkg::page_res_t       results [`PDP_PAGES],
   input  pdp_bus_pkg::word_t       sr0,
   input  logic                     pxr_rd,
   input  logic [7:0]               pxr_addr,
   output pdp_bus_pkg::ram_req_t    ram_req,
   output logic [`PDP_PAGES-1:0]    set_w,
   output logic                     abort,
   output logic [2:0]               abort_cause,
   output mmu_pkg::page_idx_t       abort_page,
   output logic                     bus_error,
   output pdp_bus_pkg::word_t       pxr_data_out
);

   import pdp_bus_pkg::*;
   import mmu_pkg::*;

   page_idx_t  page;
   page_res_t  sel;
   logic [2:0] cause;
   logic [7:0] pdr_off;
   logic [7:0] par_off;
   page_cfg_t  rd_cfg;
   word_t      rd_data;

   // ----------------------------------------------------------------------
   // translation path
   // ----------------------------------------------------------------------

   assign page = req.va[15:13];
   assign sel = results[page];
   assign cause = {sel.abort_nr, sel.abort_len, sel.abort_ro};
   assign abort = (req.rd || req.wr) && mmu_enable && (|cause);
   assign abort_cause = cause;
   assign abort_page = page;

   always_comb
   begin
      if (mmu_enable)
         ram_req.pa = sel.pa;
      else if (page == 3'd7)
         ram_req.pa = {2'b11, req.va};   // I/O page at top of memory
      else
         ram_req.pa = {2'b00, req.va};
      ram_req.data = req.data;
      ram_req.rd = req.rd && !abort;
      ram_req.wr = req.wr && !abort;
      ram_req.byte_op = req.byte_op;
   end

   always_comb
   begin
      set_w = '0;
      if (mmu_enable && req.wr && !abort)
         set_w[page] = 1'b1;
   end

   always_ff @(posedge sysclk)
   begin
      if (rst)
         bus_error <= 1'b0;
      else
         bus_error <= abort;
   end

   // ----------------------------------------------------------------------
   // register readback
   // ----------------------------------------------------------------------

   assign pdr_off = pxr_addr - 8'(`PDP_PXR_PDR_BASE);
   assign par_off = pxr_addr - 8'(`PDP_PXR_PAR_BASE);

   always_comb
   begin
      rd_data = '0;
      rd_cfg = cfgs[page_idx_t'(pdr_off)];
      if (pdr_off < 8'(`PDP_PAGES))
         rd_data = {1'b0, rd_cfg.plf, 1'b0, rd_cfg.w, 2'b00, rd_cfg.ed, rd_cfg.acf};
      else if (par_off < 8'(`PDP_PAGES))
         rd_data = {4'h0, cfgs[page_idx_t'(par_off)].par};
      else if (pxr_addr == 8'(`PDP_PXR_SR0))
         rd_data = sr0;
   end

   // held until the next read
   always_ff @(posedge sysclk)
   begin
      if (pxr_rd)
         pxr_data_out <= rd_data;
   end

   a_one_strobe: assert property (@(posedge sysclk) disable iff (rst)
      !(req.rd && req.wr));

   // mapped RAM writes only reach read/write pages
   a_mapped_wr: assert property (@(posedge sysclk) disable iff (rst)
      (ram_req.wr && mmu_enable) |-> (cfgs[page].acf == acf_rw));

endmodule

// ==== mmu_page.sv ====
/*
 * MMU page unit
 * one page's address and descriptor registers, relocation and checks
 */

module mmu_page
(
   input  logic                 sysclk,
   input  logic                 rst,
   input  logic                 pdr_wr,
   input  logic                 par_wr,
   input  mmu_pkg::pxr_wr_t     wr_data,
   input  logic                 set_w,
   input  pdp_bus_pkg::vaddr_t  va,
   input  logic                 wr,
   output mmu_pkg::page_cfg_t   cfg,
   output mmu_pkg::page_res_t   res
);

   import pdp_bus_pkg::*;
   import mmu_pkg::*;

   block_t blk;
   paddr_t base;
   paddr_t offset;

   // ----------------------------------------------------------------------
   // page registers
   // ----------------------------------------------------------------------

   always_ff @(posedge sysclk)
   begin
      if (rst)
      begin
         cfg.par <= '0;
         cfg.plf <= '0;
         cfg.ed <= 1'b0;
         cfg.acf <= acf_none;
         cfg.w <= 1'b0;
      end
      else
      begin
         if (par_wr && wr_data.be[0])
            cfg.par[7:0] <= wr_data.data[7:0];
         if (par_wr && wr_data.be[1])
            cfg.par[11:8] <= wr_data.data[11:8];

         if (pdr_wr && wr_data.be[0])
         begin
            cfg.ed <= wr_data.data[3];
            cfg.acf <= acf_t'(wr_data.data[2:0]);
         end
         if (pdr_wr && wr_data.be[1])
            cfg.plf <= wr_data.data[14:8];

         // descriptor write wins over a same-cycle set
         if (pdr_wr)
            cfg.w <= 1'b0;
         else if (set_w)
            cfg.w <= 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // translation of the current address
   // ----------------------------------------------------------------------

   assign blk = va[12:6];
   assign base = {cfg.par, 6'b000000};
   assign offset = {5'b00000, va[12:0]};

   always_comb
   begin
      res.pa = base + offset;
      res.abort_nr = !(cfg.acf == acf_ro || cfg.acf == acf_rw);
      // expand-down pages keep blocks at or above plf
      res.abort_len = cfg.ed ? (blk < cfg.plf) : (blk > cfg.plf);
      res.abort_ro = wr && (cfg.acf == acf_ro);
   end

endmodule

// ==== mmu_regs.sv ====
/*
 * MMU register decoder
 * per-page write strobes, SR0 with enable bit and abort capture
 */

`include "pdp_config.svh"

module mmu_regs
(
   input  logic                     sysclk,
   input  logic                     rst,
   input  logic                     pxr_wr,
   input  logic                     pxr_rd,
   input  logic [1:0]               pxr_be,
   input  logic [7:0]               pxr_addr,
   input  pdp_bus_pkg::word_t       pxr_data_in,
   input  logic                     abort,
   input  logic [2:0]               abort_cause,
   input  mmu_pkg::page_idx_t       abort_page,
   output logic [`PDP_PAGES-1:0]    pdr_wr,
   output logic [`PDP_PAGES-1:0]    par_wr,
   output mmu_pkg::pxr_wr_t         wr_data,
   output pdp_bus_pkg::word_t       sr0,
   output logic                     mmu_enable
);

   logic [7:0] pdr_off;
   logic [7:0] par_off;
   logic       pdr_hit;
   logic       par_hit;
   logic       sr0_hit;
   // set by the first abort, cleared by any SR0 write
   logic       frozen;

   assign pdr_off = pxr_addr - 8'(`PDP_PXR_PDR_BASE);
   assign par_off = pxr_addr - 8'(`PDP_PXR_PAR_BASE);
   assign pdr_hit = pdr_off < 8'(`PDP_PAGES);
   assign par_hit = par_off < 8'(`PDP_PAGES);
   assign sr0_hit = pxr_addr == 8'(`PDP_PXR_SR0);

   // the pages capture on the next edge
   assign pdr_wr = (pxr_wr && pdr_hit) ? `PDP_PAGES'(1) << pdr_off[2:0] : '0;
   assign par_wr = (pxr_wr && par_hit) ? `PDP_PAGES'(1) << par_off[2:0] : '0;
   assign wr_data.data = pxr_data_in;
   assign wr_data.be = pxr_be;

   assign mmu_enable = sr0[0];

   always_ff @(posedge sysclk)
   begin
      if (rst)
      begin
         sr0 <= '0;
         frozen <= 1'b0;
      end
      else if (pxr_wr && sr0_hit)
      begin
         if (pxr_be[0])
            sr0[7:0] <= pxr_data_in[7:0];
         if (pxr_be[1])
            sr0[15:8] <= pxr_data_in[15:8];
         frozen <= 1'b0;
      end
      else if (abort && !frozen)
      begin
         // cause in 15:13 (nr, len, ro), page in 3:1
         sr0[15:13] <= abort_cause;
         sr0[3:1] <= abort_page;
         frozen <= 1'b1;
      end
   end

   // register port only ever addresses the page registers and SR0
   a_pxr_mapped: assert property (@(posedge sysclk) disable iff (rst)
      (pxr_wr || pxr_rd) |-> (pdr_hit || par_hit || sr0_hit));

endmodule

// ==== mmu_pkg.sv ====
/*
 * MMU types
 * page registers, access control codes and per-page translation result
 */

package mmu_pkg;

   typedef logic [2:0] page_idx_t;

   // page base in 64-byte blocks
   typedef logic [11:0] par_t;

   // block within a page, also the length field
   typedef logic [6:0] block_t;

   // access control, unlisted codes act as not resident
   typedef enum logic [2:0] {
      acf_none = 3'd0,
      acf_ro   = 3'd2,
      acf_rw   = 3'd6
   } acf_t;

   // descriptor layout: plf [14:8], w [6], ed [3], acf [2:0]
   typedef struct packed {
      par_t   par;
      block_t plf;
      logic   ed;
      acf_t   acf;
      logic   w;
   } page_cfg_t;

   typedef struct packed {
      pdp_bus_pkg::paddr_t pa;
      logic                abort_nr;
      logic                abort_len;
      logic                abort_ro;
   } page_res_t;

   // broadcast write data for the page registers
   typedef struct packed {
      pdp_bus_pkg::word_t data;
      logic [1:0]         be;
   } pxr_wr_t;

endpackage

// ==== pdp_bus_pkg.sv ====
/*
 * PDP bus types
 * CPU virtual cycle and RAM physical cycle
 */

package pdp_bus_pkg;

   // 16-bit virtual address from the CPU
   typedef logic [15:0] vaddr_t;

   // 18-bit physical byte address
   typedef logic [17:0] paddr_t;

   typedef logic [15:0] word_t;

   // one CPU cycle request, rd and wr are one-cycle strobes
   typedef struct packed {
      vaddr_t va;
      word_t  data;
      logic   rd;
      logic   wr;
      logic   byte_op;
   } bus_req_t;

   // one RAM cycle, for byte writes the byte sits in data[7:0]
   typedef struct packed {
      paddr_t pa;
      word_t  data;
      logic   rd;
      logic   wr;
      logic   byte_op;
   } ram_req_t;

endpackage

// ==== pdp_config.svh ====
/*
 * PDP memory path configuration
 * page count, RAM size and the page register address map
 */

`ifndef PDP_CONFIG_SVH
`define PDP_CONFIG_SVH

// ----------------------------------------------------------------------
// sizes
// ----------------------------------------------------------------------

// one kernel set of pages, each 8 KB of virtual space
`define PDP_PAGES 8

// log2 of RAM depth in 16-bit words
`define PDP_RAM_ADDR_BITS 14

// ----------------------------------------------------------------------
// page register port addresses
// ----------------------------------------------------------------------

`define PDP_PXR_PDR_BASE 0
`define PDP_PXR_PAR_BASE 8
`define PDP_PXR_SR0 16

`endif
